//--- logic/booth_mul_core.sv
`timescale 1ns/1ps

module booth_mul_core
	import mul_types_pkg::*;
	import mul_ctrl_pkg::*;
#(
	parameter int XLEN = mul_types_pkg::XLEN
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        flush,
	input  logic        prod_ready,
	mul_operand_if.sink opnd,
	output logic        prod_valid,
	output prod_t       prod
);

	// step counts, one booth digit per step
	localparam int FULL_STEPS = XLEN / 2 + 1;
	localparam int WORD_STEPS = XLEN / 4 + 1;

	// fewer steps leave the product this far up in the accumulator
	localparam int WORD_SHIFT = 2 * (FULL_STEPS - WORD_STEPS);

	// upper part holds sign extended 2x multiplicand plus carry room
	localparam int UP_W  = XLEN + 4;
	localparam int LOW_W = XLEN + 2;
	localparam int ACC_W = UP_W + LOW_W;

	localparam step_t FULL_STEPS_T = step_t'(FULL_STEPS);
	localparam step_t WORD_STEPS_T = step_t'(WORD_STEPS);

	core_state_t state;
	step_t       steps_left;
	logic        load;

	ext_t             mcand_q;
	logic [XLEN+2:0]  mplier_q;
	logic             word_q;
	logic signed [ACC_W-1:0] acc;

	logic signed [UP_W-1:0]  m1;
	logic signed [UP_W-1:0]  m2;
	logic signed [UP_W-1:0]  pp;
	logic signed [UP_W-1:0]  upper_sum;
	logic signed [ACC_W-1:0] acc_step;
	logic signed [ACC_W-1:0] acc_aligned;

	// **********************************************************
	// handshakes
	// **********************************************************

	// new pair only when idle
	assign opnd.ready = (state == CORE_IDLE);
	assign load       = opnd.ready && opnd.valid;
	assign prod_valid = (state == CORE_DONE);

	// **********************************************************
	// control FSM
	// **********************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= CORE_IDLE;
			steps_left <= '0;
		end else if (flush) begin
			// drop whatever is running or waiting to leave
			state <= CORE_IDLE;
		end else begin
			unique case (state)
				CORE_IDLE: begin
					if (opnd.valid) begin
						state      <= CORE_RUN;
						steps_left <= opnd.word ? WORD_STEPS_T : FULL_STEPS_T;
					end
				end
				CORE_RUN: begin
					steps_left <= steps_left - 1'b1;
					// last digit handled this cycle
					if (steps_left == step_t'(1)) begin
						state <= CORE_DONE;
					end
				end
				CORE_DONE: begin
					if (prod_ready) begin
						state <= CORE_IDLE;
					end
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// **********************************************************
	// booth datapath
	// **********************************************************

	// multiplicand and its double, sign extended to the upper width
	assign m1 = {{2{mcand_q[XLEN+1]}}, mcand_q};
	assign m2 = m1 <<< 1;

	// radix-4 recode of the three lowest multiplier bits
	always_comb begin
		unique case (mplier_q[2:0])
			3'b001, 3'b010: pp = m1;
			3'b011:         pp = m2;
			3'b100:         pp = -m2;
			3'b101, 3'b110: pp = -m1;
			default:        pp = '0;
		endcase
	end

	// add into the top, then two bits down keeping the sign
	assign upper_sum = acc[ACC_W-1 -: UP_W] + pp;
	assign acc_step  = $signed({upper_sum, acc[LOW_W-1:0]}) >>> 2;

	always_ff @(posedge clk) begin
		if (load) begin
			mcand_q  <= opnd.mcand;
			// appended zero is the implicit bit right of the lsb
			mplier_q <= {opnd.mplier, 1'b0};
			word_q   <= opnd.word;
			acc      <= '0;
		end else if (state == CORE_RUN) begin
			acc      <= acc_step;
			mplier_q <= $signed(mplier_q) >>> 2;
		end
	end

	// realign, word mode stopped early so shift it the rest of the way
	assign acc_aligned = word_q ? (acc >>> WORD_SHIFT) : acc;
	assign prod        = acc_aligned[2*XLEN-1:0];

endmodule

//--- logic/mul_ctrl_pkg.sv
package mul_ctrl_pkg;

	import mul_types_pkg::*;

	// **********************************************************
	// booth core control
	// **********************************************************

	// idle waits for operands, run iterates, done holds the product
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_RUN,
		CORE_DONE
	} core_state_t;

	// remaining booth steps
	// full mode needs XLEN/2+1 steps
	typedef logic [$clog2(XLEN/2+2)-1:0] step_t;

endpackage

//--- logic/mul_operand_if.sv
`timescale 1ns/1ps

interface mul_operand_if
	import mul_types_pkg::*;
();

	// handshake
	logic valid;
	logic ready;

	// conditioned operands, already extended per sign mode
	ext_t mcand;
	ext_t mplier;

	// word mode flag, picks the shorter step count
	logic word;

	// operand stage side
	modport source (
		output valid,
		output mcand,
		output mplier,
		output word,
		input  ready
	);

	// booth core side
	modport sink (
		input  valid,
		input  mcand,
		input  mplier,
		input  word,
		output ready
	);

endinterface

//--- logic/mul_operand_stage.sv
`timescale 1ns/1ps

module mul_operand_stage
	import mul_types_pkg::*;
#(
	parameter int XLEN = mul_types_pkg::XLEN
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          flush,
	input  logic          mul_valid,
	output logic          mul_ready,
	input  logic          mulw,
	input  sign_mode_t    mul_signed,
	input  xlen_t         multiplicand,
	input  xlen_t         multiplier,
	mul_operand_if.source opnd
);

	// low half used in word mode
	localparam int HALF = XLEN / 2;

	// **********************************************************
	// operand conditioning
	// **********************************************************

	// pick full word or low half, then extend to XLEN+2 bits
	function automatic ext_t extend_operand(xlen_t value, logic word, logic is_signed);
		logic sign_bit;
		ext_t ext;
		if (word) begin
			sign_bit = is_signed & value[HALF-1];
			ext = {{(XLEN+2-HALF){sign_bit}}, value[HALF-1:0]};
		end else begin
			sign_bit = is_signed & value[XLEN-1];
			ext = {{2{sign_bit}}, value};
		end
		return ext;
	endfunction

	ext_t mcand_ext;
	ext_t mplier_ext;

	assign mcand_ext  = extend_operand(multiplicand, mulw, mul_signed[SIGN_MCAND]);
	assign mplier_ext = extend_operand(multiplier, mulw, mul_signed[SIGN_MPLIER]);

	// **********************************************************
	// holding register
	// **********************************************************

	logic held_valid;
	logic accept;
	ext_t mcand_q;
	ext_t mplier_q;
	logic word_q;

	// free slot, or the core takes the held pair on this edge
	assign mul_ready = !held_valid || opnd.ready;
	assign accept    = mul_valid && mul_ready;

	// a new request wins even on flush, flush only drops the old one
	always_ff @(posedge clk) begin
		if (rst) begin
			held_valid <= 1'b0;
		end else if (accept) begin
			held_valid <= 1'b1;
		end else if (flush || opnd.ready) begin
			held_valid <= 1'b0;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (accept) begin
			mcand_q  <= mcand_ext;
			mplier_q <= mplier_ext;
			word_q   <= mulw;
		end
	end

	// offered to the core from the edge after acceptance
	assign opnd.valid  = held_valid;
	assign opnd.mcand  = mcand_q;
	assign opnd.mplier = mplier_q;
	assign opnd.word   = word_q;

endmodule

//--- logic/mul_result_stage.sv
`timescale 1ns/1ps

module mul_result_stage
	import mul_types_pkg::*;
#(
	parameter int XLEN = mul_types_pkg::XLEN
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  flush,
	input  logic  prod_valid,
	output logic  prod_ready,
	input  prod_t prod,
	output logic  res_valid,
	input  logic  res_ready,
	output xlen_t result_hi,
	output xlen_t result_lo
);

	prod_t result_q;
	logic  load;

	// **********************************************************
	// result register
	// **********************************************************

	// empty, or the execute stage drains it this edge
	assign prod_ready = !res_valid || res_ready;
	assign load       = prod_valid && prod_ready;

	// flush beats a load, the incoming product is stale
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (flush) begin
			res_valid <= 1'b0;
		end else if (load) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	// holds steady while res_valid waits
	always_ff @(posedge clk) begin
		if (load) begin
			result_q <= prod;
		end
	end

	// split toward the execute stage
	assign result_hi = result_q[2*XLEN-1:XLEN];
	assign result_lo = result_q[XLEN-1:0];

endmodule

//--- logic/mul_types_pkg.sv
package mul_types_pkg;

	// **********************************************************
	// data widths
	// **********************************************************

	// machine word, rv64 by default
	parameter int XLEN = 64;

	// one operand or one half of the product
	typedef logic [XLEN-1:0] xlen_t;

	// full double width product, hi half on top
	typedef logic [2*XLEN-1:0] prod_t;

	// operand after sign or zero extension
	// two extra bits so the unsigned range fits the signed booth core
	typedef logic [XLEN+1:0] ext_t;

	// **********************************************************
	// sign mode
	// **********************************************************

	// bit 1 for multiplicand, bit 0 for multiplier
	typedef logic [1:0] sign_mode_t;

	// bit positions inside sign_mode_t
	localparam int SIGN_MCAND  = 1;
	localparam int SIGN_MPLIER = 0;

endpackage

//--- logic/mul_unit.sv
`timescale 1ns/1ps

module mul_unit
	import mul_types_pkg::*;
#(
	parameter int XLEN = mul_types_pkg::XLEN
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       mul_valid,
	output logic       mul_ready,
	input  logic       flush,
	input  logic       mulw,
	input  sign_mode_t mul_signed,
	input  xlen_t      multiplicand,
	input  xlen_t      multiplier,
	output logic       res_valid,
	input  logic       res_ready,
	output xlen_t      result_hi,
	output xlen_t      result_lo
);

	// **********************************************************
	// internal links
	// **********************************************************

	// operand pair from input side to the booth core
	mul_operand_if opnd_if ();

	// product from core to result register
	logic  prod_valid;
	logic  prod_ready;
	prod_t prod;

	// request side, one waiting slot
	mul_operand_stage #(.XLEN(XLEN)) u_operand (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.mul_ready    (mul_ready),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.opnd         (opnd_if.source)
	);

	// iterative radix-4 multiply
	booth_mul_core #(.XLEN(XLEN)) u_core (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.prod_ready (prod_ready),
		.opnd       (opnd_if.sink),
		.prod_valid (prod_valid),
		.prod       (prod)
	);

	// result side, holds under back-pressure
	mul_result_stage #(.XLEN(XLEN)) u_result (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.prod_valid (prod_valid),
		.prod_ready (prod_ready),
		.prod       (prod),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.result_hi  (result_hi),
		.result_lo  (result_lo)
	);

endmodule

//--- sim/mul_unit_tb.sv
`timescale 1ns/1ps

module mul_unit_tb
	import mul_types_pkg::*;
();

	localparam int HALF = XLEN / 2;
	// random requests per sign mode and width
	localparam int N_RAND = 4;
	// random, corner, back-pressure and flush requests
	localparam int NUM_REQ = 8 * N_RAND + 128 + 24 + 9;
	localparam int WATCHDOG_NS = (NUM_REQ * 40 + 1000) * 20;

	logic       clk = 1'b0;
	logic       rst;
	logic       mul_valid;
	logic       mul_ready;
	logic       flush;
	logic       mulw;
	sign_mode_t mul_signed;
	xlen_t      multiplicand;
	xlen_t      multiplier;
	logic       res_valid;
	logic       res_ready;
	xlen_t      result_hi;
	xlen_t      result_lo;

	int    seed = 33273;
	int    mismatch_count = 0;
	int    error_count = 0;
	int    n_accepted = 0;
	int    n_discarded = 0;
	int    n_results = 0;
	// 0 always ready, 1 random stretches, 2 held low
	int    ready_mode = 0;
	int    stretch = 0;
	prod_t expected_q[$];
	prod_t front;
	logic  waiting;
	logic  flush_seen;
	xlen_t held_hi;
	xlen_t held_lo;

	mul_unit #(.XLEN(XLEN)) UUT (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.mul_ready    (mul_ready),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.res_valid    (res_valid),
		.res_ready    (res_ready),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ************************************************************
	// reference model
	// ************************************************************

	// low half in word mode and sign bit copied only when the mode bit is set
	function automatic prod_t extend_to_prod(xlen_t v, logic sgn, logic word);
		prod_t e;
		if (word) begin
			e = {{(2*XLEN-HALF){sgn & v[HALF-1]}}, v[HALF-1:0]};
		end else begin
			e = {{XLEN{sgn & v[XLEN-1]}}, v};
		end
		return e;
	endfunction

	// product mod 2^(2*XLEN) of the extended values is the exact product
	function automatic prod_t ref_product(xlen_t a, xlen_t b, sign_mode_t mode, logic word);
		prod_t ea;
		prod_t eb;
		ea = extend_to_prod(a, mode[1], word);
		eb = extend_to_prod(b, mode[0], word);
		return ea * eb;
	endfunction

	function automatic xlen_t rand_word();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return xlen_t'(r);
	endfunction

	// zero, all ones, most negative, one
	// word mode keeps random junk in the upper half
	function automatic xlen_t corner_value(int idx, logic word);
		xlen_t           full_c;
		logic [HALF-1:0] half_c;
		xlen_t           junk;
		junk = rand_word();
		case (idx)
			0: begin
				full_c = '0;
				half_c = '0;
			end
			1: begin
				full_c = '1;
				half_c = '1;
			end
			2: begin
				full_c = {1'b1, {(XLEN-1){1'b0}}};
				half_c = {1'b1, {(HALF-1){1'b0}}};
			end
			default: begin
				full_c = xlen_t'(1);
				half_c = 1;
			end
		endcase
		return word ? {junk[XLEN-1:HALF], half_c} : full_c;
	endfunction

	// ************************************************************
	// checks
	// ************************************************************

	task automatic compare_half(string name, xlen_t expected, xlen_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: expected %h, actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic compare_count(string name, int expected, int actual);
		if (actual < expected) begin
			error_count++;
			$display("%s: only %0d of %0d expected results came back", name, actual, expected);
		end else if (actual > expected) begin
			error_count++;
			$display("%s: %0d results came back, %0d expected", name, actual, expected);
		end
	endtask

	// ************************************************************
	// stimulus helpers called at a falling edge
	// ************************************************************

	// holds the request until taken and logs its expected product
	task automatic send_request(xlen_t a, xlen_t b, sign_mode_t mode, logic word);
		multiplicand = a;
		multiplier   = b;
		mul_signed   = mode;
		mulw         = word;
		mul_valid    = 1'b1;
		// mul_ready only depends on registered state
		while (!mul_ready) begin
			@(negedge clk);
		end
		expected_q.push_back(ref_product(a, b, mode, word));
		n_accepted++;
		@(negedge clk);
		mul_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	// execute stage readiness
	always @(negedge clk) begin
		if (ready_mode == 0) begin
			res_ready = 1'b1;
		end else if (ready_mode == 2) begin
			res_ready = 1'b0;
		end else if (stretch == 0) begin
			res_ready = $random(seed);
			stretch = {$random(seed)} % 64;
		end else begin
			stretch--;
		end
	end

	// ************************************************************
	// result checker
	// ************************************************************

	always @(posedge clk) begin
		if (rst) begin
			waiting    = 1'b0;
			flush_seen = 1'b0;
		end else begin
			// a waiting result must hold still
			if (waiting && res_valid) begin
				compare_half("result_hi", held_hi, result_hi);
				compare_half("result_lo", held_lo, result_lo);
			end else if (waiting && !flush_seen) begin
				error_count++;
				$display("res_valid dropped before its result transferred at %0t", $time);
			end
			if (res_valid && res_ready) begin
				if (expected_q.size() == 0) begin
					error_count++;
					$display("a result arrived with no request pending at %0t", $time);
				end else begin
					front = expected_q.pop_front();
					compare_half("result_hi", front[2*XLEN-1:XLEN], result_hi);
					compare_half("result_lo", front[XLEN-1:0], result_lo);
				end
				n_results++;
			end
			waiting    = res_valid && !res_ready;
			held_hi    = result_hi;
			held_lo    = result_lo;
			flush_seen = flush;
		end
	end

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		int m;
		int i;
		int j;
		int w;
		int gap;
		rst          = 1'b1;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		mulw         = 1'b0;
		mul_signed   = '0;
		multiplicand = '0;
		multiplier   = '0;
		res_ready    = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle outputs after reset
		@(negedge clk);
		if (res_valid) begin
			error_count++;
			$display("res_valid is high right after reset");
		end
		if (!mul_ready) begin
			error_count++;
			$display("mul_ready is low right after reset");
		end

		// random operands in full width then in word mode
		for (w = 0; w < 2; w++) begin
			for (m = 0; m < 4; m++) begin
				for (i = 0; i < N_RAND; i++) begin
					send_request(rand_word(), rand_word(), sign_mode_t'(m), w[0]);
				end
			end
		end

		// every corner pair in both widths
		for (w = 0; w < 2; w++) begin
			for (m = 0; m < 4; m++) begin
				for (i = 0; i < 4; i++) begin
					for (j = 0; j < 4; j++) begin
						send_request(corner_value(i, w[0]), corner_value(j, w[0]),
							sign_mode_t'(m), w[0]);
					end
				end
			end
		end
		wait_drain();

		// fill all three stages with res_ready low
		ready_mode = 2;
		repeat (2) @(negedge clk);
		for (i = 0; i < 3; i++) begin
			send_request(rand_word(), rand_word(), sign_mode_t'($random(seed)), 1'b0);
		end
		if (mul_ready) begin
			error_count++;
			$display("mul_ready stayed high with every stage full");
		end
		repeat (60) @(negedge clk);

		// random stalls with requests offered often
		ready_mode = 1;
		for (i = 0; i < 21; i++) begin
			send_request(rand_word(), rand_word(), sign_mode_t'($random(seed)),
				$random(seed));
			gap = {$random(seed)} % 3;
			repeat (gap) @(negedge clk);
		end
		ready_mode = 0;
		wait_drain();

		// flush with work in the result register, the core and the holding register
		ready_mode = 2;
		repeat (2) @(negedge clk);
		send_request(rand_word(), rand_word(), 2'b11, 1'b0);
		send_request(rand_word(), rand_word(), 2'b01, 1'b1);
		send_request(rand_word(), rand_word(), 2'b10, 1'b0);
		repeat (10) @(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		n_discarded += expected_q.size();
		expected_q.delete();
		if (res_valid || !mul_ready) begin
			error_count++;
			$display("unit not empty after flush");
		end
		ready_mode = 0;
		for (i = 0; i < 6; i++) begin
			send_request(rand_word(), rand_word(), sign_mode_t'(i), i[0]);
		end
		wait_drain();

		compare_count("results", n_accepted - n_discarded, n_results);
		$display("mismatches %0d, other errors %0d", mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// hang guard sized from the request count
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("mismatches %0d, other errors %0d", mismatch_count, error_count + 1);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog.f
logic/mul_types_pkg.sv
logic/mul_ctrl_pkg.sv
logic/mul_operand_if.sv
logic/mul_operand_stage.sv
logic/booth_mul_core.sv
logic/mul_result_stage.sv
logic/mul_unit.sv
sim/mul_unit_tb.sv
